// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_1r1w
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

HEADERS := mem_settings.svh
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bank_unit.sv
`include "mem_settings.svh"

module bank_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mem_cmd_pkg::bank_cmd_t cmd,
  output mem_cmd_pkg::bank_rsp_t rsp
);
  import mem_cmd_pkg::*;

  logic [`MEM_WIDTH-1:0] mem [`MEM_NUMVROW];

  // Single port, one access per edge
  always_ff @(posedge clk) begin
    case (cmd.op)
      BANK_WRITE: begin
        mem[cmd.row] <= cmd.data;
      end
      BANK_READ: begin
        rsp <= '{data: mem[cmd.row]};
      end
      default: begin
      end
    endcase
  end

  // Controller only ever issues the three defined opcodes
  a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
    cmd.op inside {BANK_IDLE, BANK_READ, BANK_WRITE});

endmodule

// File: build.f
+incdir+.
mem_addr_pkg.sv
mem_cmd_pkg.sv
dl_map_ctrl.sv
bank_unit.sv
read_merge.sv
mem_1r1w_top.sv
tb_mem_1r1w.sv

// File: dl_map_ctrl.sv
`include "mem_settings.svh"

module dl_map_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    refr,
  input  logic                    read,
  input  logic                    write,
  input  mem_addr_pkg::vaddr_t    rd_adr,
  input  mem_addr_pkg::vaddr_t    wr_adr,
  input  logic [`MEM_WIDTH-1:0]   din,
  output logic                    ready,
  output logic                    refr_late,
  output mem_cmd_pkg::bank_cmd_t  bank_cmd [`MEM_NUMPBNK],
  output mem_cmd_pkg::read_tag_t  rd_tag
);
  import mem_addr_pkg::*;
  import mem_cmd_pkg::*;

  typedef logic [$clog2(`MEM_REFFREQ+1)-1:0] refr_cnt_t;

  ctrl_state_e state;
  vrow_t       init_row;

  // Physical bank of each logical bank, and the spare, per row
  pbank_t map_q   [`MEM_NUMVROW][`MEM_NUMVBNK];
  pbank_t spare_q [`MEM_NUMVROW];

  logic   rd_en;
  logic   wr_en;
  vbank_t rd_vb;
  vbank_t wr_vb;
  vrow_t  rd_row;
  vrow_t  wr_row;
  pbank_t rd_pb;
  pbank_t wr_map_pb;
  pbank_t wr_spare_pb;
  pbank_t wr_pb;
  logic   conflict;

  bank_op_e              op_nxt  [`MEM_NUMPBNK];
  vrow_t                 row_nxt [`MEM_NUMPBNK];
  bank_op_e              op_q    [`MEM_NUMPBNK];
  vrow_t                 row_q   [`MEM_NUMPBNK];
  logic [`MEM_WIDTH-1:0] data_q  [`MEM_NUMPBNK];

  logic  tag_vld_q;
  padr_t tag_padr_q;

  refr_cnt_t refr_cnt;

  assign ready = (state == CTRL_RUN);
  assign rd_en = ready && read;
  assign wr_en = ready && write;

  assign rd_vb  = addr_bank(rd_adr);
  assign rd_row = addr_row(rd_adr);
  assign wr_vb  = addr_bank(wr_adr);
  assign wr_row = addr_row(wr_adr);

  assign rd_pb       = map_q[rd_row][rd_vb];
  assign wr_map_pb   = map_q[wr_row][wr_vb];
  assign wr_spare_pb = spare_q[wr_row];

  // Write that lands on the read's bank moves to its row's spare
  assign conflict = rd_en && wr_en && (wr_map_pb == rd_pb);
  assign wr_pb    = conflict ? wr_spare_pb : wr_map_pb;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= CTRL_INIT;
      init_row <= '0;
    end else if (state == CTRL_INIT) begin
      init_row <= init_row + 1'b1;
      if (init_row == vrow_t'(`MEM_NUMVROW - 1)) begin
        state <= CTRL_RUN;
      end
    end
  end

  // Identity map one row per cycle during init, swap on conflict after
  always_ff @(posedge clk) begin
    if (state == CTRL_INIT) begin
      for (int v = 0; v < `MEM_NUMVBNK; v++) begin
        map_q[init_row][v] <= pbank_t'(v);
      end
      spare_q[init_row] <= pbank_t'(`MEM_NUMVBNK);
    end else if (conflict) begin
      map_q[wr_row][wr_vb] <= wr_spare_pb;
      spare_q[wr_row]      <= wr_map_pb;
    end
  end

  always_comb begin
    for (int b = 0; b < `MEM_NUMPBNK; b++) begin
      op_nxt[b]  = BANK_IDLE;
      row_nxt[b] = rd_row;
      if (rd_en && (rd_pb == pbank_t'(b))) begin
        op_nxt[b] = BANK_READ;
      end
      if (wr_en && (wr_pb == pbank_t'(b))) begin
        op_nxt[b]  = BANK_WRITE;
        row_nxt[b] = wr_row;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < `MEM_NUMPBNK; b++) begin
        op_q[b] <= BANK_IDLE;
      end
      tag_vld_q <= 1'b0;
    end else begin
      for (int b = 0; b < `MEM_NUMPBNK; b++) begin
        op_q[b] <= op_nxt[b];
      end
      tag_vld_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < `MEM_NUMPBNK; b++) begin
      row_q[b] <= row_nxt[b];
      if (op_nxt[b] == BANK_WRITE) begin
        data_q[b] <= din;
      end
    end
    tag_padr_q <= '{pbank: rd_pb, row: rd_row};
  end

  always_comb begin
    for (int b = 0; b < `MEM_NUMPBNK; b++) begin
      bank_cmd[b] = '{op: op_q[b], row: row_q[b], data: data_q[b]};
    end
    rd_tag = '{vld: tag_vld_q, padr: tag_padr_q};
  end

  // Cycles since last refr, counted only once ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refr_cnt  <= '0;
      refr_late <= 1'b0;
    end else if (!ready || refr) begin
      refr_cnt <= '0;
    end else begin
      if (refr_cnt != refr_cnt_t'(`MEM_REFFREQ)) begin
        refr_cnt <= refr_cnt + 1'b1;
      end
      if (refr_cnt == refr_cnt_t'(`MEM_REFFREQ - 1)) begin
        refr_late <= 1'b1;
      end
    end
  end

  // Read keeps its bank even when a write shares the cycle
  a_read_owns_bank: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_en && wr_en) |=> (bank_cmd[rd_tag.padr.pbank].op == BANK_READ));

  a_refr_no_access: assert property (@(posedge clk) disable iff (!rst_n)
    refr |-> !(read || write));

endmodule

// File: mem_1r1w_top.sv
`include "mem_settings.svh"

module mem_1r1w_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  refr,
  input  logic                  write,
  input  mem_addr_pkg::vaddr_t  wr_adr,
  input  logic [`MEM_WIDTH-1:0] din,
  input  logic                  read,
  input  mem_addr_pkg::vaddr_t  rd_adr,
  output logic                  ready,
  output logic                  rd_vld,
  output logic [`MEM_WIDTH-1:0] rd_dout,
  output mem_addr_pkg::padr_t   rd_padr,
  output logic                  refr_late
);
  import mem_cmd_pkg::*;

  bank_cmd_t bank_cmd [`MEM_NUMPBNK];
  bank_rsp_t bank_rsp [`MEM_NUMPBNK];
  read_tag_t rd_tag;

  dl_map_ctrl dl_map_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .refr      (refr),
    .read      (read),
    .write     (write),
    .rd_adr    (rd_adr),
    .wr_adr    (wr_adr),
    .din       (din),
    .ready     (ready),
    .refr_late (refr_late),
    .bank_cmd  (bank_cmd),
    .rd_tag    (rd_tag)
  );

  genvar i;
  generate
    for (i = 0; i < `MEM_NUMPBNK; i++) begin : bank_loop
      bank_unit bank_unit_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (bank_cmd[i]),
        .rsp   (bank_rsp[i])
      );
    end
  endgenerate

  read_merge read_merge_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_tag   (rd_tag),
    .bank_rsp (bank_rsp),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rd_padr  (rd_padr)
  );

endmodule

// File: mem_addr_pkg.sv
`include "mem_settings.svh"

package mem_addr_pkg;

  // Logical address, row in the upper bits and bank in the low bits
  typedef logic [`MEM_BITVROW+`MEM_BITVBNK-1:0] vaddr_t;

  typedef logic [`MEM_BITVBNK-1:0] vbank_t;
  typedef logic [`MEM_BITPBNK-1:0] pbank_t;
  typedef logic [`MEM_BITVROW-1:0] vrow_t;

  // Physical location of a word
  typedef struct packed {
    pbank_t pbank;
    vrow_t  row;
  } padr_t;

  function automatic vbank_t addr_bank(vaddr_t adr);
    return adr[`MEM_BITVBNK-1:0];
  endfunction

  function automatic vrow_t addr_row(vaddr_t adr);
    return adr[`MEM_BITVBNK +: `MEM_BITVROW];
  endfunction

endpackage

// File: mem_cmd_pkg.sv
`include "mem_settings.svh"

package mem_cmd_pkg;

  typedef enum logic [1:0] {
    BANK_IDLE  = 2'd0,
    BANK_READ  = 2'd1,
    BANK_WRITE = 2'd2
  } bank_op_e;

  // One command per physical bank per cycle
  typedef struct packed {
    bank_op_e              op;
    mem_addr_pkg::vrow_t   row;
    logic [`MEM_WIDTH-1:0] data;
  } bank_cmd_t;

  typedef struct packed {
    logic [`MEM_WIDTH-1:0] data;
  } bank_rsp_t;

  // Which bank answers a read, travels alongside the bank access
  typedef struct packed {
    logic                vld;
    mem_addr_pkg::padr_t padr;
  } read_tag_t;

  typedef enum logic {
    CTRL_INIT = 1'b0,
    CTRL_RUN  = 1'b1
  } ctrl_state_e;

endpackage

// File: mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Data word width
`define MEM_WIDTH 16

// Logical banks, plus one spare physical bank
`define MEM_NUMVBNK 4
`define MEM_NUMPBNK 5

// Rows per bank
`define MEM_NUMVROW 16
`define MEM_BITVROW 4

// Bank index widths
`define MEM_BITVBNK 2
`define MEM_BITPBNK 3

// Longest allowed gap between refr pulses, in cycles
`define MEM_REFFREQ 16

`endif

// File: read_merge.sv
`include "mem_settings.svh"

module read_merge (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mem_cmd_pkg::read_tag_t rd_tag,
  input  mem_cmd_pkg::bank_rsp_t bank_rsp [`MEM_NUMPBNK],
  output logic                   rd_vld,
  output logic [`MEM_WIDTH-1:0]  rd_dout,
  output mem_addr_pkg::padr_t    rd_padr
);
  import mem_addr_pkg::*;

  // Tag delayed to line up with the registered bank read
  logic  tag_vld_d;
  padr_t tag_padr_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_vld_d <= 1'b0;
      rd_vld    <= 1'b0;
    end else begin
      tag_vld_d <= rd_tag.vld;
      rd_vld    <= tag_vld_d;
    end
  end

  always_ff @(posedge clk) begin
    tag_padr_d <= rd_tag.padr;
    if (tag_vld_d) begin
      rd_dout <= bank_rsp[tag_padr_d.pbank].data;
      rd_padr <= tag_padr_d;
    end
  end

  a_tag_to_vld: assert property (@(posedge clk) disable iff (!rst_n)
    rd_tag.vld |-> ##2 rd_vld);

endmodule

// File: tb_mem_1r1w.sv
`include "mem_settings.svh"

module tb_mem_1r1w;
  timeunit 1ns;
  timeprecision 1ps;

  import mem_addr_pkg::*;

  localparam int CYCLE_LIMIT = 2000;
  localparam int REFR_EVERY  = 8;
  localparam int RAND_CYCLES = 400;
  localparam int NUM_ADDR    = `MEM_NUMVROW * `MEM_NUMVBNK;

  typedef logic [`MEM_WIDTH-1:0] word_t;

  typedef struct packed {
    word_t dout;
    padr_t padr;
  } rd_exp_t;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   refr;
  logic   write;
  vaddr_t wr_adr;
  word_t  din;
  logic   read;
  vaddr_t rd_adr;
  logic   ready;
  logic   rd_vld;
  word_t  rd_dout;
  padr_t  rd_padr;
  logic   refr_late;

  // Reference memory by logical address, plus its own location map
  word_t  ref_mem   [NUM_ADDR];
  pbank_t ref_map   [`MEM_NUMVROW][`MEM_NUMVBNK];
  pbank_t ref_spare [`MEM_NUMVROW];

  rd_exp_t     exp_q[$];
  rd_exp_t     exp_cur;
  logic        chk_vld      = 1'b0;
  logic        late_allowed = 1'b0;
  logic [2:0]  rd_hist      = '0;
  int          err_cnt      = 0;
  int          err_mark     = 0;
  int          chk_cnt      = 0;
  int          test_cnt     = 0;
  int          refr_gap     = 0;
  int          cyc_cnt      = 0;

  mem_1r1w_top mem_1r1w_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .refr      (refr),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .read      (read),
    .rd_adr    (rd_adr),
    .ready     (ready),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr),
    .refr_late (refr_late)
  );

  always #20 clk = ~clk;

  // Accepted reads, oldest in bit 2
  always @(posedge clk) begin
    rd_hist <= {rd_hist[1:0], read && ready};
  end

  // Line up the next expected read with the cycle rd_vld is high
  always @(negedge clk) begin
    if (rd_vld) begin
      if (exp_q.size() == 0) begin
        $display("rd_vld went high with no read outstanding");
        err_cnt++;
        chk_vld = 1'b0;
      end else begin
        exp_cur = exp_q.pop_front();
        chk_vld = 1'b1;
        chk_cnt++;
      end
    end else begin
      chk_vld = 1'b0;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !ready && !rd_vld && !refr_late)
    else begin
      $display("CHECK FAILED ready/rd_vld/refr_late exp=0/0/0 got=%h/%h/%h",
               $sampled(ready), $sampled(rd_vld), $sampled(refr_late));
      err_cnt++;
    end

  a_init_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !ready |-> !rd_vld && !refr_late)
    else begin
      $display("CHECK FAILED rd_vld/refr_late exp=0 got=%h/%h",
               $sampled(rd_vld), $sampled(refr_late));
      err_cnt++;
    end

  a_vld_timing: assert property (@(posedge clk) disable iff (!rst_n) rd_vld == rd_hist[2])
    else begin
      $display("CHECK FAILED rd_vld exp=%h got=%h", $sampled(rd_hist[2]), $sampled(rd_vld));
      err_cnt++;
    end

  a_rd_dout: assert property (@(posedge clk) disable iff (!rst_n)
    chk_vld |-> rd_dout == exp_cur.dout)
    else begin
      $display("CHECK FAILED rd_dout exp=%h got=%h", exp_cur.dout, $sampled(rd_dout));
      err_cnt++;
    end

  a_rd_padr: assert property (@(posedge clk) disable iff (!rst_n)
    chk_vld |-> rd_padr == exp_cur.padr)
    else begin
      $display("CHECK FAILED rd_padr exp=%h got=%h", exp_cur.padr, $sampled(rd_padr));
      err_cnt++;
    end

  a_late_low: assert property (@(posedge clk) disable iff (!rst_n)
    !late_allowed |-> !refr_late)
    else begin
      $display("CHECK FAILED refr_late exp=0 got=%h", $sampled(refr_late));
      err_cnt++;
    end

  task automatic reset_model();
    for (int r = 0; r < `MEM_NUMVROW; r++) begin
      for (int v = 0; v < `MEM_NUMVBNK; v++) begin
        ref_map[r][v] = pbank_t'(v);
      end
      ref_spare[r] = pbank_t'(`MEM_NUMVBNK);
    end
  endtask

  // One access cycle, with an idle refr cycle slipped in when due
  task automatic drive_cycle(input logic rd, input vaddr_t ra, input logic wr,
                             input vaddr_t wa, input word_t d);
    vrow_t   rd_row;
    pbank_t  rd_pb;
    vrow_t   wr_row;
    vbank_t  wr_vb;
    pbank_t  wr_pb;
    rd_exp_t rd_exp;
    if (refr_gap == REFR_EVERY - 1) begin
      @(negedge clk);
      refr     = 1'b1;
      read     = 1'b0;
      write    = 1'b0;
      refr_gap = 0;
    end
    @(negedge clk);
    refr   = 1'b0;
    read   = rd;
    rd_adr = ra;
    write  = wr;
    wr_adr = wa;
    din    = d;
    refr_gap++;
    rd_row = ra[`MEM_BITVBNK +: `MEM_BITVROW];
    rd_pb  = ref_map[rd_row][ra[`MEM_BITVBNK-1:0]];
    // Read sees memory before this cycle's write
    if (rd) begin
      rd_exp.dout = ref_mem[ra];
      rd_exp.padr = '{pbank: rd_pb, row: rd_row};
      exp_q.push_back(rd_exp);
    end
    if (wr) begin
      wr_row = wa[`MEM_BITVBNK +: `MEM_BITVROW];
      wr_vb  = wa[`MEM_BITVBNK-1:0];
      wr_pb  = ref_map[wr_row][wr_vb];
      if (rd && (wr_pb == rd_pb)) begin
        ref_map[wr_row][wr_vb] = ref_spare[wr_row];
        ref_spare[wr_row]      = wr_pb;
      end
      ref_mem[wa] = d;
    end
  endtask

  task automatic drain_reads();
    while (exp_q.size() != 0) begin
      drive_cycle(1'b0, '0, 1'b0, '0, '0);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
    test_cnt++;
  endtask

  initial begin : timeout_watch
    while (cyc_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int init_cycles;
    void'($urandom(65181));
    rst_n  = 1'b0;
    refr   = 1'b0;
    read   = 1'b0;
    write  = 1'b0;
    rd_adr = '0;
    wr_adr = '0;
    din    = '0;
    reset_model();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    init_cycles = 0;
    while (!ready) begin
      @(negedge clk);
      init_cycles++;
    end
    a_init_len: assert (init_cycles == `MEM_NUMVROW)
      else begin
        $display("CHECK FAILED ready delay exp=%h got=%h", `MEM_NUMVROW, init_cycles);
        err_cnt++;
      end
    finish_test("init");

    for (int a = 0; a < NUM_ADDR; a++) begin
      drive_cycle(1'b0, '0, 1'b1, vaddr_t'(a), word_t'($urandom));
    end
    for (int a = 0; a < NUM_ADDR; a++) begin
      drive_cycle(1'b1, vaddr_t'(a), 1'b0, '0, '0);
    end
    drain_reads();
    finish_test("write_read");

    // Same address, then different rows on one physical bank
    drive_cycle(1'b1, 6'd5, 1'b1, 6'd5, 16'ha5a5);
    drive_cycle(1'b1, 6'd0, 1'b1, 6'd4, 16'h5a5a);
    drive_cycle(1'b1, 6'd5, 1'b0, '0, '0);
    drive_cycle(1'b1, 6'd4, 1'b0, '0, '0);
    drive_cycle(1'b1, 6'd0, 1'b0, '0, '0);
    drain_reads();
    finish_test("conflict");

    for (int i = 0; i < RAND_CYCLES; i++) begin
      drive_cycle(($urandom % 4) != 0, vaddr_t'($urandom),
                  ($urandom % 2) == 1, vaddr_t'($urandom), word_t'($urandom));
    end
    drain_reads();
    finish_test("random");

    repeat (6 * REFR_EVERY) drive_cycle(1'b0, '0, 1'b0, '0, '0);
    @(negedge clk);
    refr         = 1'b1;
    late_allowed = 1'b1;
    // Late flag rises after REFFREQ silent cycles and ignores a later refr
    for (int j = 1; j <= `MEM_REFFREQ + 4; j++) begin
      @(negedge clk);
      refr = (j == `MEM_REFFREQ + 2);
      a_late_edge: assert (refr_late == (j > `MEM_REFFREQ))
        else begin
          $display("CHECK FAILED refr_late exp=%h got=%h", j > `MEM_REFFREQ, refr_late);
          err_cnt++;
        end
    end
    refr = 1'b0;
    finish_test("refresh");

    $display("tests=%0d reads checked=%0d errors=%0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
